/* build.f */
+incdir+include
hdl/lspcSpritePkg.sv
hdl/lspcPbusPkg.sv
hdl/spriteLineIf.sv
hdl/spriteLineCalc.sv
hdl/tileAnimator.sv
hdl/pBusMux.sv
hdl/pBusFetch.sv
test/pBusFetch_assertions.sv
test/pBusFetchTb.sv

/* Makefile */
# Verilator build and run of the P-bus fetch testbench
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := pBusFetchTb
FILELIST := build.f
OBJDIR   := obj_dir
PASSMSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

/* test/pBusFetchTb.sv */
// Testbench for the P-bus fetch path, reference model with queued word checks
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

module pBusFetchTb;
	import lspcSpritePkg::*;
	import lspcPbusPkg::*;

	localparam int ClkPeriod = 20;
	localparam int ResetCycles = 8;
	localparam int DriveDelay = 2;
	localparam int AddrVectors = 200;
	localparam int TileVectors = 128;
	localparam int FixVectors = 64;
	localparam int BurstVectors = 128;
	// Speeds 0, 1 and 3, ten count steps each
	localparam int FramePulses = 70;
	localparam int NumVectors = AddrVectors + TileVectors + FixVectors + BurstVectors
		+ FramePulses;
	localparam int DrainNs = 1000;
	localparam int WatchdogNs = NumVectors * 40 + ResetCycles * ClkPeriod + DrainNs;

	// ==========================================================
	// DUT signals
	// ==========================================================
	logic                        CLK = 1'b0;
	logic                        nRESETP;
	logic                        slotStrobe;
	logic [1:0]                  slotSel;
	logic [8:0]                  rasterLine;
	logic                        flip;
	logic                        pixelPhase;
	logic                        frameStart;
	logic [7:0]                  aaSpeed;
	logic                        aaDisable;
	logic [`LSPC_TILE_W-1:0]     sprTile;
	logic [7:0]                  sprPalette;
	logic                        sprVFlip;
	logic                        sprAa3;
	logic                        sprAa2;
	logic [8:0]                  sprY;
	logic [`LSPC_SIZE_W-1:0]     sprSize;
	logic [7:0]                  sprYShrink;
	logic [3:0]                  vshrinkLine;
	logic [3:0]                  vshrinkIndex;
	logic [`LSPC_FIX_TILE_W-1:0] fixTile;
	logic [3:0]                  fixPalette;
	logic [`LSPC_PBUS_W-1:0]     pBus;
	logic                        pBusValid;
	logic [15:0]                 loRomAddr;
	aaCount_t                    aaCount;
	logic                        spriteMapMsb;
	logic [3:0]                  tilemapIndex;

	// Checker state, owned by the compare process
	pBusWord_u   expWords[$];
	int          expCycles[$];
	pBusWord_u   gotWord;
	pBusWord_u   frontWord;
	int          frontCycle;
	int          cycleCnt = 0;
	logic [7:0]  modelFrameCnt = 8'd0;
	aaCount_t    modelCount = '0;
	logic [7:0]  expLine;
	logic        lineMirror;
	logic [15:0] expLoAddr = 16'd0;
	logic [3:0]  expIndex = 4'd0;
	logic        expMapMsb = 1'b0;
	logic        addrKnown = 1'b0;
	logic        resetChecked = 1'b0;
	sprAttr_t    curAttr;
	int          wordErrors = 0;
	int          addrErrors = 0;
	int          mapErrors = 0;
	int          countErrors = 0;
	int          otherErrors = 0;
	int          missingWords;
	logic [31:0] seedValue;

	pBusFetch u_pBusFetch (
		.CLK          (CLK),
		.nRESETP      (nRESETP),
		.slotStrobe   (slotStrobe),
		.slotSel      (slotSel),
		.rasterLine   (rasterLine),
		.flip         (flip),
		.pixelPhase   (pixelPhase),
		.frameStart   (frameStart),
		.aaSpeed      (aaSpeed),
		.aaDisable    (aaDisable),
		.sprTile      (sprTile),
		.sprPalette   (sprPalette),
		.sprVFlip     (sprVFlip),
		.sprAa3       (sprAa3),
		.sprAa2       (sprAa2),
		.sprY         (sprY),
		.sprSize      (sprSize),
		.sprYShrink   (sprYShrink),
		.vshrinkLine  (vshrinkLine),
		.vshrinkIndex (vshrinkIndex),
		.fixTile      (fixTile),
		.fixPalette   (fixPalette),
		.pBus         (pBus),
		.pBusValid    (pBusValid),
		.loRomAddr    (loRomAddr),
		.aaCount      (aaCount),
		.spriteMapMsb (spriteMapMsb),
		.tilemapIndex (tilemapIndex)
	);

	bind pBusFetch pBusFetchAssertions u_pBusFetchAssertions (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.slotStrobe (slotStrobe),
		.slotSel    (slotSel),
		.frameStart (frameStart),
		.pBus       (pBus),
		.pBusValid  (pBusValid),
		.aaCount    (aaCount)
	);

	always #(ClkPeriod / 2) CLK = ~CLK;

	// ==========================================================
	// Reference model
	// ==========================================================

	// LO line in plain integer arithmetic, mirror returned alongside
	function automatic logic [7:0] refLoLine(input sprAttr_t a, input logic [8:0] raster,
		input logic flipIn, output logic mirror);
		int   look;
		int   sum;
		int   lineA;
		int   lineB;
		int   shrinkInv;
		logic bottom;
		logic cont;
		look = (int'(raster[7:1]) * 2 + int'(flipIn) + 1) % 256;
		sum = look + int'(a.yPos[7:0]);
		// Carry out disagreeing with Y sign bit
		bottom = a.yPos[8] ^ (sum >= 256);
		lineA = bottom ? 255 - (sum % 256) : sum % 256;
		shrinkInv = 255 - int'(a.yShrink);
		cont = a.ySize[0] & a.ySize[5] & (lineA + shrinkInv >= 256);
		lineB = (lineA + (shrinkInv % 128) * 2) % 256;
		mirror = bottom ^ cont;
		return cont ? 8'(255 - lineB) : 8'(lineA);
	endfunction

	function automatic pBusWord_u expectWord(input pBusSlot_t slot, input sprAttr_t a,
		input logic [8:0] raster, input logic flipIn, input logic phase,
		input logic [`LSPC_FIX_TILE_W-1:0] fTile, input logic [3:0] fPal,
		input logic aaOff, input aaCount_t cnt);
		pBusWord_u  w;
		logic [7:0] line;
		logic       mirror;
		sprTile_t   tile;
		logic       en2;
		logic       en10;
		w = '0;
		line = refLoLine(a, raster, flipIn, mirror);
		en2 = a.aa3 & ~aaOff;
		en10 = en2 | (a.aa2 & ~aaOff);
		tile = a.tile;
		if (en2)
			tile[2] = cnt[2];
		if (en10)
			tile[1:0] = cnt[1:0];
		case (slot)
			SLOT_ADDR: begin
				w.addr.palette = a.palette;
				w.addr.yShrink = a.yShrink;
				w.addr.loLine = line;
			end
			SLOT_TILE: begin
				w.tile.tileHigh = tile[19:16];
				w.tile.line = a.vshrinkLine ^ {4{mirror ^ a.vFlip}};
				w.tile.tileMid = tile[15:3];
				w.tile.tileAnim = tile[2:0];
			end
			SLOT_FIX: begin
				w.fix.palette = fPal;
				w.fix.pixelPhase = phase;
				w.fix.rasterBits = raster[2:1];
				w.fix.flip = flipIn;
				w.fix.tile = fTile;
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	function automatic sprAttr_t packAttr();
		sprAttr_t a;
		a.tile = sprTile;
		a.palette = sprPalette;
		a.vFlip = sprVFlip;
		a.aa3 = sprAa3;
		a.aa2 = sprAa2;
		a.yPos = sprY;
		a.ySize = sprSize;
		a.yShrink = sprYShrink;
		a.vshrinkLine = vshrinkLine;
		a.vshrinkIndex = vshrinkIndex;
		return a;
	endfunction

	// ==========================================================
	// Compare tasks
	// ==========================================================
	task automatic checkWord(input string name, input pBusWord_u got, input pBusWord_u exp);
		if (got !== exp) begin
			wordErrors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			addrErrors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkIndex(input string name, input logic [3:0] got,
		input logic [3:0] exp);
		if (got !== exp) begin
			mapErrors++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mapErrors++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic checkCount(input string name, input aaCount_t got, input aaCount_t exp);
		if (got !== exp) begin
			countErrors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Outputs compared mid-cycle, then next edge's inputs predicted
	always @(negedge CLK) begin
		cycleCnt = cycleCnt + 1;
		gotWord = pBus;
		if (!nRESETP) begin
			modelFrameCnt = 8'd0;
			modelCount = '0;
			addrKnown = 1'b0;
		end else begin
			if (!resetChecked) begin
				resetChecked = 1'b1;
				if (pBusValid !== 1'b0) begin
					otherErrors++;
					$display("pBusValid is high right after reset at %0t ns", $time);
				end
				checkWord("pBus", gotWord, '0);
			end
			checkCount("aaCount", aaCount, modelCount);
			if (addrKnown) begin
				checkAddr("loRomAddr", loRomAddr, expLoAddr);
				checkIndex("tilemapIndex", tilemapIndex, expIndex);
				checkFlag("spriteMapMsb", spriteMapMsb, expMapMsb);
			end
			if (pBusValid === 1'b1) begin
				if (expWords.size() == 0) begin
					otherErrors++;
					$display("pBusValid went high at %0t ns with no word pending", $time);
				end else begin
					frontWord = expWords.pop_front();
					frontCycle = expCycles.pop_front();
					if (cycleCnt != frontCycle + `LSPC_PIPE_DEPTH) begin
						otherErrors++;
						$display("Word strobed in cycle %0d came out in cycle %0d",
							frontCycle, cycleCnt);
					end
					checkWord("pBus", gotWord, frontWord);
				end
			end else if (expWords.size() > 0 &&
				expCycles[0] + `LSPC_PIPE_DEPTH <= cycleCnt) begin
				otherErrors++;
				$display("pBusValid stayed low at %0t ns for the word strobed in cycle %0d",
					$time, expCycles[0]);
				frontWord = expWords.pop_front();
				frontCycle = expCycles.pop_front();
			end
			// Inputs here are the ones the next edge samples
			curAttr = packAttr();
			if (slotStrobe) begin
				expWords.push_back(expectWord(pBusSlot_t'(slotSel), curAttr, rasterLine,
					flip, pixelPhase, fixTile, fixPalette, aaDisable, modelCount));
				expCycles.push_back(cycleCnt);
				expLine = refLoLine(curAttr, rasterLine, flip, lineMirror);
				expLoAddr = {sprYShrink, expLine};
				expIndex = vshrinkIndex ^ {4{lineMirror}};
				expMapMsb = lineMirror;
				addrKnown = 1'b1;
			end
			// Count steps after aaSpeed+1 frames
			if (frameStart) begin
				if (modelFrameCnt == aaSpeed) begin
					modelFrameCnt = 8'd0;
					modelCount = aaCount_t'((int'(modelCount) + 1) % 8);
				end else begin
					modelFrameCnt = modelFrameCnt + 8'd1;
				end
			end
		end
	end

	// ==========================================================
	// Stimulus
	// ==========================================================
	task automatic waitDrive();
		@(posedge CLK);
		#DriveDelay;
	endtask

	task automatic randomizeSprite();
		rasterLine = 9'($urandom);
		flip = 1'($urandom);
		pixelPhase = 1'($urandom);
		sprTile = 20'($urandom);
		sprPalette = 8'($urandom);
		sprVFlip = 1'($urandom);
		sprAa3 = 1'($urandom);
		sprAa2 = 1'($urandom);
		sprY = 9'($urandom);
		sprSize = 6'($urandom);
		sprYShrink = 8'($urandom);
		vshrinkLine = 4'($urandom);
		vshrinkIndex = 4'($urandom);
		fixTile = 12'($urandom);
		fixPalette = 4'($urandom);
	endtask

	initial begin
		seedValue = $urandom(85);
		nRESETP = 1'b0;
		slotStrobe = 1'b0;
		slotSel = SLOT_IDLE;
		frameStart = 1'b0;
		aaSpeed = 8'd0;
		aaDisable = 1'b0;
		randomizeSprite();
		repeat (ResetCycles) @(posedge CLK);
		#DriveDelay;
		nRESETP = 1'b1;

		// Address slots, every other one forced to height-33 style
		for (int i = 0; i < AddrVectors; i++) begin
			waitDrive();
			randomizeSprite();
			if (i % 2 == 0)
				sprSize = {1'b1, 4'($urandom), 1'b1};
			slotStrobe = 1'b1;
			slotSel = SLOT_ADDR;
			waitDrive();
			slotStrobe = 1'b0;
		end

		// Tile slots over all enable combos, count moving underneath
		for (int i = 0; i < TileVectors; i++) begin
			waitDrive();
			randomizeSprite();
			{sprAa3, sprAa2, aaDisable} = 3'(i);
			slotStrobe = 1'b1;
			slotSel = SLOT_TILE;
			frameStart = 1'($urandom);
			waitDrive();
			slotStrobe = 1'b0;
			frameStart = 1'b0;
		end

		// Fix and idle
		for (int i = 0; i < FixVectors; i++) begin
			waitDrive();
			randomizeSprite();
			slotStrobe = 1'b1;
			slotSel = i[0] ? SLOT_IDLE : SLOT_FIX;
			waitDrive();
			slotStrobe = 1'b0;
		end

		// Strobe every cycle, mixed slots
		for (int i = 0; i < BurstVectors; i++) begin
			waitDrive();
			randomizeSprite();
			aaDisable = 1'($urandom);
			slotStrobe = 1'b1;
			slotSel = 2'($urandom);
			frameStart = 1'($urandom);
		end
		waitDrive();
		slotStrobe = 1'b0;
		frameStart = 1'b0;

		// Frame pulses at speeds 0, 1 and 3
		for (int s = 0; s < 3; s++) begin
			waitDrive();
			aaSpeed = 8'((1 << s) - 1);
			for (int f = 0; f < 10 * (int'(aaSpeed) + 1); f++) begin
				waitDrive();
				frameStart = 1'b1;
				waitDrive();
				frameStart = 1'b0;
			end
		end

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		missingWords = expWords.size();
		if (missingWords != 0)
			$display("%0d expected words never appeared on pBus", missingWords);
		$display("Errors: word %0d, address %0d, map %0d, count %0d, other %0d, missing %0d",
			wordErrors, addrErrors, mapErrors, countErrors, otherErrors, missingWords);
		if (wordErrors + addrErrors + mapErrors + countErrors + otherErrors
			+ missingWords == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog sized from the vector count
	initial begin
		#(WatchdogNs);
		$display("Watchdog expired after %0d ns, the run did not finish", WatchdogNs);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* test/pBusFetch_assertions.sv */
// Concurrent checks on P-bus valid timing, idle words and animation count steps
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

module pBusFetchAssertions (
	input wire logic                     CLK,
	input wire logic                     nRESETP,
	input wire logic                     slotStrobe,
	input wire logic [1:0]               slotSel,
	input wire logic                     frameStart,
	input wire logic [`LSPC_PBUS_W-1:0]  pBus,
	input wire logic                     pBusValid,
	input wire lspcSpritePkg::aaCount_t  aaCount
);
	import lspcPbusPkg::*;

	localparam int PipeDepth = `LSPC_PIPE_DEPTH;

	// ==========================================================
	// Pipeline timing
	// ==========================================================

	// Every strobe gives a valid two edges later
	strobeToValid: assert property (@(posedge CLK) disable iff (!nRESETP)
		slotStrobe |-> ##PipeDepth pBusValid)
		else $error("pBusValid missing two cycles after slotStrobe");

	// And no valid without a strobe behind it
	validHasStrobe: assert property (@(posedge CLK) disable iff (!nRESETP)
		pBusValid |-> $past(slotStrobe, PipeDepth))
		else $error("pBusValid without a slotStrobe two cycles earlier");

	// Idle slot drives an all-zero word
	idleIsZero: assert property (@(posedge CLK) disable iff (!nRESETP)
		slotStrobe && slotSel == SLOT_IDLE |-> ##PipeDepth (pBus == '0))
		else $error("Idle slot gave a nonzero P-bus word");

	// ==========================================================
	// Animation counter
	// ==========================================================
	countStep: assert property (@(posedge CLK) disable iff (!nRESETP)
		aaCount != $past(aaCount) |-> $past(frameStart) && aaCount == $past(aaCount) + 3'd1)
		else $error("aaCount moved other than by one on a frameStart");

endmodule

`default_nettype wire

/* hdl/pBusFetch.sv */
// P-bus fetch path top, sprite line, tile animation and slot mux
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

module pBusFetch (
	input  wire logic                        CLK,
	input  wire logic                        nRESETP,
	// Slot timing
	input  wire logic                        slotStrobe,
	input  wire logic [1:0]                  slotSel,
	input  wire logic [8:0]                  rasterLine,
	input  wire logic                        flip,
	input  wire logic                        pixelPhase,
	// Auto-animation control
	input  wire logic                        frameStart,
	input  wire logic [7:0]                  aaSpeed,
	input  wire logic                        aaDisable,
	// Sprite attributes
	input  wire logic [`LSPC_TILE_W-1:0]     sprTile,
	input  wire logic [7:0]                  sprPalette,
	input  wire logic                        sprVFlip,
	input  wire logic                        sprAa3,
	input  wire logic                        sprAa2,
	input  wire logic [8:0]                  sprY,
	input  wire logic [`LSPC_SIZE_W-1:0]     sprSize,
	input  wire logic [7:0]                  sprYShrink,
	// LO ROM lookup data
	input  wire logic [3:0]                  vshrinkLine,
	input  wire logic [3:0]                  vshrinkIndex,
	// Fix layer
	input  wire logic [`LSPC_FIX_TILE_W-1:0] fixTile,
	input  wire logic [3:0]                  fixPalette,
	output logic [`LSPC_PBUS_W-1:0]          pBus,
	output logic                             pBusValid,
	output logic [15:0]                      loRomAddr,
	output logic [`LSPC_AA_W-1:0]            aaCount,
	output logic                             spriteMapMsb,
	output logic [3:0]                       tilemapIndex
);
	import lspcSpritePkg::*;
	import lspcPbusPkg::*;

	sprAttr_t  attr;
	pBusSlot_t slot;
	sprTile_t  tileWord;
	pBusWord_u pBusWord;

	spriteLineIf lineIf ();

	// ==========================================================
	// Input packing
	// ==========================================================
	assign slot = pBusSlot_t'(slotSel);

	assign attr = '{
		tile:         sprTile,
		palette:      sprPalette,
		vFlip:        sprVFlip,
		aa3:          sprAa3,
		aa2:          sprAa2,
		yPos:         sprY,
		ySize:        sprSize,
		yShrink:      sprYShrink,
		vshrinkLine:  vshrinkLine,
		vshrinkIndex: vshrinkIndex
	};

	// Stage one, line math
	spriteLineCalc u_spriteLineCalc (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.slotStrobe (slotStrobe),
		.slotSel    (slot),
		.attr       (attr),
		.rasterLine (rasterLine),
		.flip       (flip),
		.lineOut    (lineIf.calc),
		.loRomAddr  (loRomAddr)
	);

	// Stage one, animated tile
	tileAnimator u_tileAnimator (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.slotStrobe (slotStrobe),
		.frameStart (frameStart),
		.aaSpeed    (aaSpeed),
		.aaDisable  (aaDisable),
		.sprTile    (sprTile),
		.sprAa3     (sprAa3),
		.sprAa2     (sprAa2),
		.tileWord   (tileWord),
		.aaCount    (aaCount)
	);

	// Stage two, slot mux
	pBusMux u_pBusMux (
		.CLK        (CLK),
		.nRESETP    (nRESETP),
		.lineIn     (lineIf.mux),
		.tileWord   (tileWord),
		.fixTile    (fixTile),
		.fixPalette (fixPalette),
		.pixelPhase (pixelPhase),
		.rasterLine (rasterLine),
		.flip       (flip),
		.slotStrobe (slotStrobe),
		.pBus       (pBusWord),
		.pBusValid  (pBusValid)
	);

	assign pBus = pBusWord;

	// Sprite map addressing from stage one
	assign spriteMapMsb = lineIf.mapMsb;
	assign tilemapIndex = lineIf.tilemapIndex;

endmodule

`default_nettype wire

/* hdl/pBusMux.sv */
// P-bus word multiplexer for address, tile, fix and idle slots
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

module pBusMux (
	input  wire logic                        CLK,
	input  wire logic                        nRESETP,
	spriteLineIf.mux                         lineIn,
	input  wire lspcSpritePkg::sprTile_t     tileWord,
	input  wire logic [`LSPC_FIX_TILE_W-1:0] fixTile,
	input  wire logic [3:0]                  fixPalette,
	input  wire logic                        pixelPhase,
	input  wire logic [8:0]                  rasterLine,
	input  wire logic                        flip,
	input  wire logic                        slotStrobe,
	output lspcPbusPkg::pBusWord_u           pBus,
	output logic                             pBusValid
);
	import lspcPbusPkg::*;

	// Fix fields, aligned with stage one
	logic [`LSPC_FIX_TILE_W-1:0] fixTileR;
	logic [3:0]                  fixPaletteR;
	logic                        pixelPhaseR;
	logic [1:0]                  rasterBitsR;
	logic                        flipR;
	pBusWord_u                   nextWord;

	always_ff @(posedge CLK) begin
		if (slotStrobe) begin
			fixTileR <= fixTile;
			fixPaletteR <= fixPalette;
			pixelPhaseR <= pixelPhase;
			rasterBitsR <= rasterLine[2:1];
			flipR <= flip;
		end
	end

	// ==========================================================
	// Word build through slot view
	// ==========================================================
	always_comb begin
		nextWord = '0;
		case (lineIn.slot)
			SLOT_ADDR: begin
				nextWord.addr.palette = lineIn.palette;
				nextWord.addr.yShrink = lineIn.yShrink;
				nextWord.addr.loLine = lineIn.loLine;
			end
			SLOT_TILE: begin
				nextWord.tile.tileHigh = tileWord[19:16];
				nextWord.tile.line = lineIn.sprLine;
				nextWord.tile.tileMid = tileWord[15:3];
				// Already animated upstream
				nextWord.tile.tileAnim = tileWord[2:0];
			end
			SLOT_FIX: begin
				nextWord.fix.palette = fixPaletteR;
				nextWord.fix.pixelPhase = pixelPhaseR;
				nextWord.fix.rasterBits = rasterBitsR;
				nextWord.fix.flip = flipR;
				nextWord.fix.tile = fixTileR;
			end
			// Idle keeps the all-zero word
			default: nextWord = '0;
		endcase
	end

	// Output stage, word held between valids
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			pBus <= '0;
			pBusValid <= 1'b0;
		end else begin
			pBusValid <= lineIn.valid;
			if (lineIn.valid)
				pBus <= nextWord;
		end
	end

endmodule

`default_nettype wire

/* hdl/tileAnimator.sv */
// Auto-animation frame counter and animated sprite tile code
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

module tileAnimator (
	input  wire logic                     CLK,
	input  wire logic                     nRESETP,
	input  wire logic                     slotStrobe,
	input  wire logic                     frameStart,
	input  wire logic [7:0]               aaSpeed,
	input  wire logic                     aaDisable,
	input  wire lspcSpritePkg::sprTile_t  sprTile,
	input  wire logic                     sprAa3,
	input  wire logic                     sprAa2,
	output lspcSpritePkg::sprTile_t       tileWord,
	output lspcSpritePkg::aaCount_t       aaCount
);
	import lspcSpritePkg::*;

	logic [7:0] frameCnt;
	logic       enBit2;
	logic       enBits10;
	sprTile_t   animTile;

	// ==========================================================
	// Frame counter
	// ==========================================================

	// Count advances every aaSpeed+1 frames
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			frameCnt <= 8'd0;
			aaCount <= '0;
		end else if (frameStart) begin
			if (frameCnt == aaSpeed) begin
				frameCnt <= 8'd0;
				// Natural 3-bit wrap
				aaCount <= aaCount + 1'b1;
			end else begin
				frameCnt <= frameCnt + 8'd1;
			end
		end
	end

	// ==========================================================
	// Tile bit substitution
	// ==========================================================

	// 8-frame animation implies 4-frame one
	assign enBit2 = sprAa3 & ~aaDisable;
	assign enBits10 = enBit2 | (sprAa2 & ~aaDisable);

	always_comb begin
		animTile = sprTile;
		if (enBit2)
			animTile[2] = aaCount[2];
		if (enBits10)
			animTile[1:0] = aaCount[1:0];
	end

	// Sampled count is the one before any same-cycle frameStart
	always_ff @(posedge CLK) begin
		if (slotStrobe)
			tileWord <= animTile;
	end

endmodule

`default_nettype wire

/* hdl/spriteLineCalc.sv */
// Sprite line calculation, LO line, V-shrink mirroring and LO ROM address
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

module spriteLineCalc (
	input  wire logic                     CLK,
	input  wire logic                     nRESETP,
	input  wire logic                     slotStrobe,
	input  wire lspcPbusPkg::pBusSlot_t   slotSel,
	input  wire lspcSpritePkg::sprAttr_t  attr,
	input  wire logic [8:0]               rasterLine,
	input  wire logic                     flip,
	spriteLineIf.calc                     lineOut,
	output logic [15:0]                   loRomAddr
);
	import lspcPbusPkg::*;

	logic [7:0]              lookahead;
	logic [8:0]              ySum;
	logic                    bottomHalf;
	logic [`LSPC_LINE_W-1:0] loLineA;
	logic [`LSPC_LINE_W-1:0] loLineB;
	logic [`LSPC_LINE_W-1:0] loLine;
	logic [8:0]              shrinkSum;
	logic                    continuous;
	logic                    mirror;
	logic [3:0]              sprLineNext;
	logic [3:0]              tilemapNext;

	// ==========================================================
	// Y-line arithmetic
	// ==========================================================

	// Next line, flip acts as half-line LSB
	assign lookahead = {rasterLine[7:1], flip} + 8'd1;

	// Carry lands in bit 8
	assign ySum = {1'b0, lookahead} + {1'b0, attr.yPos[7:0]};

	// Wrap mismatch means lower half of sprite
	assign bottomHalf = attr.yPos[8] ^ ySum[8];
	assign loLineA = ySum[7:0] ^ {`LSPC_LINE_W{bottomHalf}};

	// Shrink sum, only the carry is needed
	assign shrinkSum = {1'b0, loLineA} + {1'b0, ~attr.yShrink};

	// Height-33 style sprite, drawn as one continuous strip
	assign continuous = attr.ySize[0] & attr.ySize[5] & shrinkSum[8];

	assign loLineB = loLineA + {~attr.yShrink[6:0], 1'b0};
	assign loLine = continuous ? ~loLineB : loLineA;

	// ==========================================================
	// V-shrink mirroring
	// ==========================================================
	assign mirror = bottomHalf ^ continuous;

	// Tile flip applies on top of mirroring
	assign sprLineNext = attr.vshrinkLine ^ {4{mirror}} ^ {4{attr.vFlip}};
	assign tilemapNext = attr.vshrinkIndex ^ {4{mirror}};

	// Stage one control
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			lineOut.valid <= 1'b0;
			lineOut.slot <= SLOT_IDLE;
		end else begin
			lineOut.valid <= slotStrobe;
			if (slotStrobe)
				lineOut.slot <= slotSel;
		end
	end

	// Stage one results, held until next strobe
	always_ff @(posedge CLK) begin
		if (slotStrobe) begin
			lineOut.sprLine <= sprLineNext;
			lineOut.loLine <= loLine;
			lineOut.yShrink <= attr.yShrink;
			lineOut.palette <= attr.palette;
			lineOut.tilemapIndex <= tilemapNext;
			lineOut.mapMsb <= mirror;
			// LO ROM address is shrink value then line
			loRomAddr <= {attr.yShrink, loLine};
		end
	end

endmodule

`default_nettype wire

/* hdl/spriteLineIf.sv */
// Sprite line interface between the line calculation and the P-bus mux
`timescale 1ns/10ps
`default_nettype none

`include "lspc_defs.svh"

interface spriteLineIf;
	import lspcPbusPkg::*;

	// Stage-one strobe and slot tag
	logic                    valid;
	pBusSlot_t               slot;

	// Line results
	logic [3:0]              sprLine;
	logic [`LSPC_LINE_W-1:0] loLine;
	logic [7:0]              yShrink;
	logic [7:0]              palette;

	// Sprite map addressing, mirrored for second half
	logic [3:0]              tilemapIndex;
	logic                    mapMsb;

	modport calc (output valid, slot, sprLine, loLine, yShrink, palette,
		tilemapIndex, mapMsb);

	modport mux (input valid, slot, sprLine, loLine, yShrink, palette);

endinterface

`default_nettype wire

/* hdl/lspcPbusPkg.sv */
// P-bus package with slot selection and the three decoded word views
`default_nettype none

`include "lspc_defs.svh"

package lspcPbusPkg;

	// ==========================================================
	// Slot selection
	// ==========================================================

	// What the controller drives on the P bus in a slot
	typedef enum logic [1:0] {
		SLOT_ADDR = 2'd0,
		SLOT_TILE = 2'd1,
		SLOT_FIX  = 2'd2,
		SLOT_IDLE = 2'd3
	} pBusSlot_t;

	// ==========================================================
	// P-bus word layouts
	// ==========================================================

	// Sprite address slot, palette on the high byte
	typedef struct packed {
		logic [7:0]              palette;
		logic [7:0]              yShrink;
		logic [`LSPC_LINE_W-1:0] loLine;
	} sprAddrWord_t;

	// Sprite tile slot, line sits between tile high and mid bits
	typedef struct packed {
		logic [3:0]  tileHigh;
		logic [3:0]  line;
		logic [12:0] tileMid;
		// Possibly replaced by animation count
		logic [2:0]  tileAnim;
	} sprTileWord_t;

	// Fix tile slot
	typedef struct packed {
		logic [3:0]                  zero;
		logic [3:0]                  palette;
		logic                        pixelPhase;
		// Raster bits 2..1, fix tile row half
		logic [1:0]                  rasterBits;
		logic                        flip;
		logic [`LSPC_FIX_TILE_W-1:0] tile;
	} fixTileWord_t;

	// Same 24 bits, decoded per slot
	typedef union packed {
		sprAddrWord_t addr;
		sprTileWord_t tile;
		fixTileWord_t fix;
	} pBusWord_u;

endpackage

`default_nettype wire

/* hdl/lspcSpritePkg.sv */
// Sprite attribute package with per-sprite input and tile code types
`default_nettype none

`include "lspc_defs.svh"

package lspcSpritePkg;

	// ==========================================================
	// Sprite tile and animation types
	// ==========================================================

	// Tile code as read from sprite map, low bits may be animated
	typedef logic [`LSPC_TILE_W-1:0] sprTile_t;

	// Auto-animation frame number, wraps 7 -> 0
	typedef logic [`LSPC_AA_W-1:0] aaCount_t;

	// ==========================================================
	// Per-sprite attributes sampled with the slot strobe
	// ==========================================================
	typedef struct packed {
		sprTile_t                tile;
		logic [7:0]              palette;
		// Vertical tile flip
		logic                    vFlip;
		// Animation enables for bit 2 and bits 1..0
		logic                    aa3;
		logic                    aa2;
		// Y position, bit 8 is the sign of the wrap
		logic [8:0]              yPos;
		logic [`LSPC_SIZE_W-1:0] ySize;
		logic [7:0]              yShrink;
		// LO ROM lookup result, line and tilemap index
		logic [3:0]              vshrinkLine;
		logic [3:0]              vshrinkIndex;
	} sprAttr_t;

endpackage

`default_nettype wire

/* include/lspc_defs.svh */
// LSPC P-bus fetch widths and pipeline constants
`ifndef LSPC_DEFS_SVH
`define LSPC_DEFS_SVH

// ==========================================================
// Bus and field widths
// ==========================================================

// Full P-bus word driven to the graphics ROMs
`define LSPC_PBUS_W 24

// LO ROM line index, low byte of the LO address
`define LSPC_LINE_W 8

// Sprite tile code from the sprite map
`define LSPC_TILE_W 20

// Fix layer tile code
`define LSPC_FIX_TILE_W 12

// Auto-animation frame number
`define LSPC_AA_W 3

// Sprite height in tiles
`define LSPC_SIZE_W 6

// Cycles from sampled strobe to P-bus valid
`define LSPC_PIPE_DEPTH 2

`endif
